// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int word_width      = 32;
    localparam int line_width      = 128;
    localparam int words_per_line  = 4;
    localparam int line_count      = 8;
    localparam int tag_width       = 25;
    localparam int index_width     = $clog2(line_count);
    localparam int offset_width    = $clog2(words_per_line);
    localparam int line_addr_width = tag_width + index_width;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } cache_view_t;

    typedef struct packed {
        logic [line_addr_width-1:0] line_addr;
        logic [offset_width-1:0]    offset;
    } mem_view_t;

    // one processor word address, split for the cache or for memory
    typedef union packed {
        cache_view_t as_cache;
        mem_view_t   as_mem;
    } word_addr_t;

    typedef logic [words_per_line-1:0][word_width-1:0] line_t; // word 0 in low bits

    typedef enum logic [1:0] {
        IDLE,
        FILL,       // read refill
        WRITE_FILL, // refill ahead of a write
        WRITE_BACK  // line going out to memory
    } state_t;

endpackage

`default_nettype wire

// File: source/cache_line_if.sv
`default_nettype none

interface cache_line_if;

    cache_pkg::word_addr_t               addr;
    logic                                fill_en;   // install fill_line, set tag and valid
    cache_pkg::line_t                    fill_line;
    logic                                word_en;   // merge word_data at the offset
    logic [cache_pkg::word_width-1:0]    word_data;
    logic                                hit;
    cache_pkg::line_t                    cur_line;  // already merged when word_en

    modport store (
        input  addr,
        input  fill_en,
        input  fill_line,
        input  word_en,
        input  word_data,
        output hit,
        output cur_line
    );

    modport ctrl (
        output addr,
        output fill_en,
        output fill_line,
        output word_en,
        output word_data,
        input  hit,
        input  cur_line
    );

endinterface

`default_nettype wire

// File: source/cache_line_store.sv
`default_nettype none

module cache_line_store (
    input  logic                             clk,
    input  logic                             proc_reset,
    cache_line_if.store                      line,
    output logic [cache_pkg::word_width-1:0] rdata
);

    logic [cache_pkg::line_count-1:0] valid;
    logic [cache_pkg::tag_width-1:0]  tag_mem  [cache_pkg::line_count];
    cache_pkg::line_t                 data_mem [cache_pkg::line_count];

    logic [cache_pkg::tag_width-1:0]    tag;
    logic [cache_pkg::index_width-1:0]  index;
    logic [cache_pkg::offset_width-1:0] offset;
    cache_pkg::line_t                   stored_line;
    cache_pkg::line_t                   next_line;

    assign tag    = line.addr.as_cache.tag;
    assign index  = line.addr.as_cache.index;
    assign offset = line.addr.as_cache.offset;

    assign stored_line = data_mem[index];
    assign line.hit    = valid[index] && (tag_mem[index] == tag);
    assign rdata       = stored_line[offset];

    // refill line or stored line with the processor word on top
    always_comb
    begin
        next_line = line.fill_en ? line.fill_line : stored_line;
        if (line.word_en)
        begin
            next_line[offset] = line.word_data;
        end
    end

    assign line.cur_line = next_line; // also the write-through data

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid <= '0;
        end
        else if (line.fill_en)
        begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line.fill_en)
        begin
            tag_mem[index] <= tag;
        end
        if (line.fill_en || line.word_en)
        begin
            data_mem[index] <= next_line;
        end
    end

    // a refill only ever replaces a line that missed
    fill_only_on_miss: assert property (
        @(posedge clk) disable iff (proc_reset)
        line.fill_en |-> !line.hit
    );

endmodule

`default_nettype wire

// File: source/cache_controller.sv
`default_nettype none

module cache_controller (
    input  logic                                  clk,
    input  logic                                  proc_reset,
    input  logic                                  proc_read,
    input  logic                                  proc_write,
    input  cache_pkg::word_addr_t                 proc_addr,
    input  logic [cache_pkg::word_width-1:0]      proc_wdata,
    input  logic [cache_pkg::word_width-1:0]      store_rdata,
    output logic [cache_pkg::word_width-1:0]      proc_rdata,
    output logic                                  proc_stall,
    output logic                                  mem_read,
    output logic                                  mem_write,
    output logic [cache_pkg::line_addr_width-1:0] mem_addr,
    output cache_pkg::line_t                      mem_wdata,
    input  cache_pkg::line_t                      mem_rdata,
    input  logic                                  mem_ready,
    cache_line_if.ctrl                            line
);

    cache_pkg::state_t state;
    cache_pkg::state_t state_next;
    logic              mem_read_next;
    logic              mem_write_next;
    logic              load_addr;  // new memory request
    logic              load_wdata; // merge edge

    assign line.addr      = proc_addr;
    assign line.fill_line = mem_rdata;
    assign line.word_data = proc_wdata;

    always_comb
    begin
        state_next     = state;
        mem_read_next  = mem_read;
        mem_write_next = mem_write;
        proc_stall     = 1'b0;
        line.fill_en   = 1'b0;
        line.word_en   = 1'b0;
        load_addr      = 1'b0;
        load_wdata     = 1'b0;
        unique case (state)
            cache_pkg::IDLE:
            begin
                if (proc_write)
                begin
                    proc_stall = 1'b1;
                    load_addr  = 1'b1;
                    if (line.hit)
                    begin
                        line.word_en   = 1'b1;
                        load_wdata     = 1'b1;
                        mem_write_next = 1'b1;
                        state_next     = cache_pkg::WRITE_BACK;
                    end
                    else
                    begin
                        mem_read_next = 1'b1;
                        state_next    = cache_pkg::WRITE_FILL;
                    end
                end
                else if (proc_read && !line.hit)
                begin
                    proc_stall    = 1'b1;
                    load_addr     = 1'b1;
                    mem_read_next = 1'b1;
                    state_next    = cache_pkg::FILL;
                end
            end
            cache_pkg::FILL:
            begin
                proc_stall = !mem_ready; // word comes straight from mem_rdata
                if (mem_ready)
                begin
                    line.fill_en  = 1'b1;
                    mem_read_next = 1'b0;
                    state_next    = cache_pkg::IDLE;
                end
            end
            cache_pkg::WRITE_FILL:
            begin
                proc_stall = 1'b1;
                if (mem_ready)
                begin
                    line.fill_en   = 1'b1;
                    line.word_en   = 1'b1;
                    load_wdata     = 1'b1;
                    mem_read_next  = 1'b0;
                    mem_write_next = 1'b1;
                    state_next     = cache_pkg::WRITE_BACK;
                end
            end
            cache_pkg::WRITE_BACK:
            begin
                proc_stall = !mem_ready;
                if (mem_ready)
                begin
                    mem_write_next = 1'b0;
                    state_next     = cache_pkg::IDLE;
                end
            end
        endcase
    end

    assign proc_rdata = (state == cache_pkg::FILL) ? mem_rdata[proc_addr.as_mem.offset]
                                                   : store_rdata;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state     <= cache_pkg::IDLE;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            mem_read  <= mem_read_next;
            mem_write <= mem_write_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_addr)
        begin
            mem_addr <= proc_addr.as_mem.line_addr; // held for the whole transfer
        end
        if (load_wdata)
        begin
            mem_wdata <= line.cur_line;
        end
    end

    mem_read_write_exclusive: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write)
    );

    mem_addr_held_while_waiting: assert property (
        @(posedge clk) disable iff (proc_reset)
        ((mem_read || mem_write) && !mem_ready) |=> $stable(mem_addr)
    );

endmodule

`default_nettype wire

// File: source/cache_top.sv
`default_nettype none

module cache_top (
    input  logic                                       clk,
    input  logic                                       proc_reset,
    input  logic                                       proc_read,
    input  logic                                       proc_write,
    input  logic [$bits(cache_pkg::word_addr_t)-1:0]   proc_addr,
    input  logic [cache_pkg::word_width-1:0]           proc_wdata,
    output logic [cache_pkg::word_width-1:0]           proc_rdata,
    output logic                                       proc_stall,
    output logic                                       mem_read,
    output logic                                       mem_write,
    output logic [cache_pkg::line_addr_width-1:0]      mem_addr,
    output logic [cache_pkg::line_width-1:0]           mem_wdata,
    input  logic [cache_pkg::line_width-1:0]           mem_rdata,
    input  logic                                       mem_ready
);

    logic [cache_pkg::word_width-1:0] store_rdata;

    cache_line_if i_line_if ();

    cache_controller i_cache_controller (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .proc_read   (proc_read),
        .proc_write  (proc_write),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .store_rdata (store_rdata),
        .proc_rdata  (proc_rdata),
        .proc_stall  (proc_stall),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .line        (i_line_if.ctrl)
    );

    cache_line_store i_cache_line_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .line       (i_line_if.store),
        .rdata      (store_rdata)
    );

endmodule

`default_nettype wire

// File: test/cache_checker.sv
`default_nettype none

module cache_checker (
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         proc_read,
    input  logic         proc_write,
    input  logic [29:0]  proc_addr,
    input  logic [31:0]  proc_wdata,
    input  logic [31:0]  proc_rdata,
    input  logic         proc_stall,
    input  logic         mem_read,
    input  logic         mem_write,
    input  logic [27:0]  mem_addr,
    input  logic [127:0] mem_wdata,
    input  logic         mem_ready,
    output int           mismatch_count,
    output int           error_count
);

    logic [31:0] shadow [logic [29:0]]; // words written so far
    logic        res_valid [8];         // lines the cache should hold now
    logic [24:0] res_tag   [8];
    int          mismatches = 0;
    int          errors     = 0;
    logic        busy       = 1'b0;
    logic        check_idle = 1'b0;
    logic        waiting    = 1'b0;
    logic        req_write;
    logic        req_hit;
    logic [29:0] req_addr;
    logic [31:0] req_wdata;
    logic        saw_read;
    int          write_count;
    logic [27:0] held_addr;
    logic        held_read;
    logic        held_write;

    assign mismatch_count = mismatches;
    assign error_count    = errors;

    function automatic logic [31:0] expected_word(input logic [29:0] addr);
        if (shadow.exists(addr))
            return shadow[addr];
        return {addr, 2'b11} ^ 32'h9e37_79b9; // memory contents before any write
    endfunction

    function automatic logic [127:0] expected_line(input logic [27:0] line_addr);
        logic [127:0] line_value;
        for (int w = 0; w < 4; w++)
            line_value[w*32 +: 32] = expected_word({line_addr, 2'(w)});
        return line_value;
    endfunction

    task automatic log_mismatch(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        $display("Mismatch %s at addr %h: expected %0h, actual %0h",
                 name, req_addr, expected, actual);
        mismatches++;
    endtask

    task automatic flag_error(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    always @(negedge clk)
    begin
        if (proc_reset)
        begin
            shadow.delete();
            for (int i = 0; i < 8; i++)
                res_valid[i] = 1'b0;
            busy       = 1'b0;
            waiting    = 1'b0;
            check_idle = 1'b1;
        end
        else
        begin
            if (check_idle && (proc_stall || mem_read || mem_write))
                flag_error("stall or memory request high right after reset");
            check_idle = 1'b0;
            if (waiting && (mem_addr !== held_addr || mem_read !== held_read
                            || mem_write !== held_write))
                flag_error("memory request changed while mem_ready was low");
            waiting    = (mem_read || mem_write) && !mem_ready;
            held_addr  = mem_addr;
            held_read  = mem_read;
            held_write = mem_write;

            if ((proc_read || proc_write) && !busy)
            begin
                busy        = 1'b1;
                req_write   = proc_write;
                req_addr    = proc_addr;
                req_wdata   = proc_wdata;
                req_hit     = res_valid[proc_addr[4:2]] && res_tag[proc_addr[4:2]] == proc_addr[29:5];
                saw_read    = 1'b0;
                write_count = 0;
                if (proc_stall != (proc_write || !req_hit))
                    flag_error(proc_stall ? "read hit stalled in its request cycle"
                                          : "miss or write did not stall in its request cycle");
            end

            if (busy)
            begin
                if (mem_read)
                    saw_read = 1'b1;
                if (mem_read && mem_ready && mem_addr !== req_addr[29:2])
                    log_mismatch("fill_addr", 128'(req_addr[29:2]), 128'(mem_addr));
                if (mem_write && mem_ready)
                    write_count++;
                if (!proc_stall)
                begin
                    if (saw_read == req_hit)
                        flag_error(req_hit ? "mem_read during a request that should hit"
                                           : "miss completed without a memory refill");
                    if (req_write)
                    begin
                        shadow[req_addr] = req_wdata;
                        if (write_count != 1)
                            flag_error($sformatf("write done with %0d memory writes", write_count));
                        if (mem_addr !== req_addr[29:2])
                            log_mismatch("write_addr", 128'(req_addr[29:2]), 128'(mem_addr));
                        if (mem_wdata !== expected_line(req_addr[29:2]))
                            log_mismatch("write_line", expected_line(req_addr[29:2]), mem_wdata);
                    end
                    else
                    begin
                        if (write_count != 0)
                            flag_error("mem_write completed during a read");
                        if (proc_rdata !== expected_word(req_addr))
                            log_mismatch("read_data", 128'(expected_word(req_addr)),
                                         128'(proc_rdata));
                    end
                    res_valid[req_addr[4:2]] = 1'b1; // line now resident
                    res_tag[req_addr[4:2]]   = req_addr[29:5];
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/cache_tb.sv
`default_nettype none

module cache_tb;

    localparam int period         = 100;
    localparam int directed_count = 8;
    localparam int random_count   = 200;
    localparam int max_latency    = 4;
    localparam int request_cycles = 2 * (max_latency + 3) + 6; // two refills plus margin
    localparam int timeout_time   = (directed_count + random_count) * request_cycles * period;
    localparam logic [29:0] base_addr = 30'h0012_3400; // 64-word aligned window

    logic         clk       = 1'b0;
    logic         proc_reset;
    logic         proc_read;
    logic         proc_write;
    logic [29:0]  proc_addr;
    logic [31:0]  proc_wdata;
    logic [31:0]  proc_rdata;
    logic         proc_stall;
    logic         mem_read;
    logic         mem_write;
    logic [27:0]  mem_addr;
    logic [127:0] mem_wdata;
    logic [127:0] mem_rdata = '0;
    logic         mem_ready = 1'b0;

    logic [127:0] mem_lines [16]; // the 16 lines of the window
    logic         mem_busy  = 1'b0;
    logic [2:0]   wait_left = '0;
    logic [31:0]  stim_seed = 32'd18851;
    logic [31:0]  mem_seed  = 32'd18851;
    int           mismatch_count;
    int           error_count;

    always #(period / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [127:0] initial_line(input logic [27:0] line_addr);
        logic [127:0] line_value;
        for (int w = 0; w < 4; w++)
        begin
            line_value[w*32 +: 32] = {line_addr, 2'(w), 2'b11} ^ 32'h9e37_79b9;
        end
        return line_value;
    endfunction

    // one processor access, held until the cache stops stalling
    task automatic run_request(input logic is_write, input logic [29:0] addr,
                               input logic [31:0] data);
        @(posedge clk);
        proc_read  <= !is_write;
        proc_write <= is_write;
        proc_addr  <= addr;
        proc_wdata <= data;
        @(negedge clk);
        while (proc_stall)
            @(negedge clk);
    endtask

    // memory model with 1 to 4 cycles of latency
    always @(posedge clk)
    begin
        if (proc_reset)
        begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
            for (int i = 0; i < 16; i++)
                mem_lines[i] <= initial_line({base_addr[29:6], 4'(i)});
        end
        else if (mem_ready)
        begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
            if (mem_write)
                mem_lines[mem_addr[3:0]] <= mem_wdata;
        end
        else if (mem_busy)
        begin
            if (wait_left == 3'd1)
            begin
                mem_ready <= 1'b1;
                mem_rdata <= mem_lines[mem_addr[3:0]];
            end
            wait_left <= wait_left - 3'd1;
        end
        else if (mem_read || mem_write)
        begin
            mem_seed = lcg_next(mem_seed);
            mem_busy  <= 1'b1;
            wait_left <= 3'd1 + 3'(mem_seed[17:16]);
        end
    end

    cache_top i_cache_top (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    cache_checker i_cache_checker (
        .clk            (clk),
        .proc_reset     (proc_reset),
        .proc_read      (proc_read),
        .proc_write     (proc_write),
        .proc_addr      (proc_addr),
        .proc_wdata     (proc_wdata),
        .proc_rdata     (proc_rdata),
        .proc_stall     (proc_stall),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_ready      (mem_ready),
        .mismatch_count (mismatch_count),
        .error_count    (error_count)
    );

    initial
    begin
        logic [29:0] addr_a;
        logic [29:0] addr_b;
        logic [29:0] addr;
        logic        is_write;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        addr_a     = base_addr + 30'd5;
        addr_b     = addr_a + 30'd32; // same index, other tag
        repeat (2) @(posedge clk);
        proc_reset <= 1'b0;

        run_request(1'b0, addr_a, 32'h0);
        run_request(1'b0, addr_a + 30'd1, 32'h0);
        run_request(1'b1, addr_a, 32'hcafe_0001);
        run_request(1'b0, addr_a, 32'h0);
        run_request(1'b0, addr_b, 32'h0);
        run_request(1'b0, addr_a, 32'h0);
        run_request(1'b1, addr_b, 32'hcafe_0002);
        run_request(1'b0, addr_b, 32'h0);

        for (int n = 0; n < random_count; n++)
        begin
            stim_seed = lcg_next(stim_seed);
            is_write  = stim_seed[27];
            addr      = {base_addr[29:6], stim_seed[21:16]};
            stim_seed = lcg_next(stim_seed);
            run_request(is_write, addr, stim_seed);
        end

        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        repeat (4) @(posedge clk);
        $display("Checker totals: %0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        #(timeout_time);
        $display("Timeout: requests still running after %0d time units", timeout_time);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/cache_pkg.sv
source/cache_line_if.sv
source/cache_line_store.sv
source/cache_controller.sv
source/cache_top.sv
test/cache_checker.sv
test/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f tb.f -o cache_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/cache_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
